// ==== test/filter_tests.txt ====
# W adr data | R adr expect | S ch sample | P s0 s1 | E ch value | X reset pulse
# all fields hex, samples and coefficients are 18-bit Q2.16
W 0 08000
W 1 04000
W 2 02000
W 3 00000
W 4 00000
W 8 10000
W 9 3C000
W A 01000
W B 3E000
W C 00000
R 0 08000
R 1 04000
R 2 02000
R 3 00000
R 4 00000
R 8 10000
R 9 3C000
R A 01000
R B 3E000
R C 00000
R 5 00000
R F 00000
E 0 08000
S 0 10000
E 0 04000
S 0 00000
E 0 02000
S 0 00000
E 0 00000
S 0 00000
W 1 00000
W 2 00000
W 3 0AAAB
E 0 08000
S 0 10000
E 0 05555
S 0 00000
E 0 038E3
S 0 00000
E 0 045EC
E 1 10000
P 04000 10000
E 1 3A123
S 1 00123
E 1 01A92
S 1 3FF00
E 0 0309D
S 0 00400
X
R 0 00000
R 8 00000
E 0 00000
S 0 10000
W 0 06000
E 0 06000
S 0 10000

// ==== all.f ====
hdl/dsp_pkg.sv
hdl/filter_pkg.sv
hdl/mac_unit.sv
hdl/dsp_arbiter.sv
hdl/iir_channel.sv
hdl/coef_regs.sv
hdl/dsp_filter_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -f all.f --top tb_top -o tb_top && ./obj_dir/tb_top | tee sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top
    import filter_pkg::*;
;

    logic     reset;    // clock pin of the DUT
    logic     clk;      // async clear pin of the DUT
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    sample_t  sample_in_0;
    logic     sample_in_rdy_0;
    sample_t  sample_out_0;
    logic     sample_out_rdy_0;
    sample_t  sample_in_1;
    logic     sample_in_rdy_1;
    sample_t  sample_out_1;
    logic     sample_out_rdy_1;

    string    lines[$];
    int       cycles;
    int       limit;

    dsp_filter_top uut (.*);

    tb_checker chk (
        .reset(reset), .wb_ack(wb_ack), .wb_we(wb_we), .wb_dat_r(wb_dat_r),
        .sample_out_0(sample_out_0), .sample_out_rdy_0(sample_out_rdy_0),
        .sample_out_1(sample_out_1), .sample_out_rdy_1(sample_out_rdy_1)
    );

    initial begin
        reset = 1'b0;
        forever #2 reset = ~reset;
    end

    // cycle limit, set once the file is loaded
    always @(posedge reset) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout reached after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------
    // bus and sample tasks
    // ----------------------------------------
    task automatic next_edge();
        @(posedge reset);
        #1;
    endtask

    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat);
        next_edge();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do next_edge(); while (!wb_ack);
        next_edge();    // stb stays up through the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic pulse_reset();
        next_edge();
        clk = 1'b1;
        repeat (10) next_edge();
        clk = 1'b0;
    endtask

    task automatic send_samples(input logic use0, input logic use1,
                                input sample_t s0, input sample_t s1);
        logic seen0;
        logic seen1;
        seen0 = !use0;
        seen1 = !use1;
        next_edge();
        sample_in_0     = s0;
        sample_in_rdy_0 = use0;
        sample_in_1     = s1;
        sample_in_rdy_1 = use1;
        next_edge();
        sample_in_rdy_0 = 1'b0;
        sample_in_rdy_1 = 1'b0;
        while (!(seen0 && seen1)) begin
            next_edge();
            if (sample_out_rdy_0) seen0 = 1'b1;
            if (sample_out_rdy_1) seen1 = 1'b1;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        byte   cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        clk             = 1'b1;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        sample_in_0     = '0;
        sample_in_rdy_0 = 1'b0;
        sample_in_1     = '0;
        sample_in_rdy_1 = 1'b0;
        cycles          = 0;
        limit           = 0;
        fd = $fopen("test/filter_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/filter_tests.txt");
            $display("sim failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") lines.push_back(line);
            end
            $fclose(fd);
            limit = 40 * lines.size() + 10;
            repeat (10) next_edge();
            clk = 1'b0;
            foreach (lines[i]) begin
                cmd = lines[i][0];
                f1  = '0;
                f2  = '0;
                n = $sscanf(lines[i].substr(2, lines[i].len() - 1), "%h %h", f1, f2);
                case (cmd)
                    "W": wb_access(1'b1, wb_addr_t'(f1), wb_data_t'(f2));
                    "R": begin
                        chk.exp_rd.push_back(wb_data_t'(f2));
                        wb_access(1'b0, wb_addr_t'(f1), '0);
                    end
                    "S": begin
                        if (f1[0]) send_samples(1'b0, 1'b1, '0, sample_t'(f2));
                        else       send_samples(1'b1, 1'b0, sample_t'(f2), '0);
                    end
                    "P": send_samples(1'b1, 1'b1, sample_t'(f1), sample_t'(f2));
                    "E": begin
                        if (f1[0]) chk.exp_q1.push_back(sample_t'(f2));
                        else       chk.exp_q0.push_back(sample_t'(f2));
                    end
                    "X": pulse_reset();
                    default: begin
                        $display("unknown command in line: %s", lines[i]);
                        chk.unexpected++;
                    end
                endcase
            end
            repeat (4) next_edge();
            chk.count_leftover();
            $display("errors: mismatch=%0d unexpected=%0d unused=%0d",
                     chk.mismatches, chk.unexpected, chk.leftover);
            if (chk.mismatches + chk.unexpected + chk.leftover == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker
    import filter_pkg::*;
(
    input logic     reset,
    input logic     wb_ack,
    input logic     wb_we,
    input wb_data_t wb_dat_r,
    input sample_t  sample_out_0,
    input logic     sample_out_rdy_0,
    input sample_t  sample_out_1,
    input logic     sample_out_rdy_1
);

    wb_data_t exp_rd[$];
    sample_t  exp_q0[$];    // one queue per channel, arbiter order is free
    sample_t  exp_q1[$];
    int       mismatches = 0;
    int       unexpected = 0;
    int       leftover   = 0;

    task automatic compare(input string what, input logic [17:0] got, input logic [17:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %05h expected %05h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // sample mid cycle, away from the clock edge
    always @(negedge reset) begin
        if (wb_ack && !wb_we) begin
            if (exp_rd.size() == 0) begin
                $display("read data %05h arrived with no expected value", wb_dat_r);
                unexpected++;
            end else begin
                compare("register read", wb_dat_r, exp_rd.pop_front());
            end
        end
        if (sample_out_rdy_0) begin
            if (exp_q0.size() == 0) begin
                $display("channel 0 output %05h arrived with no expected value", sample_out_0);
                unexpected++;
            end else begin
                compare("channel 0 output", sample_out_0, exp_q0.pop_front());
            end
        end
        if (sample_out_rdy_1) begin
            if (exp_q1.size() == 0) begin
                $display("channel 1 output %05h arrived with no expected value", sample_out_1);
                unexpected++;
            end else begin
                compare("channel 1 output", sample_out_1, exp_q1.pop_front());
            end
        end
    end

    task automatic count_leftover();
        leftover = exp_rd.size() + exp_q0.size() + exp_q1.size();
        if (leftover != 0) begin
            $display("%0d expected values were never used", leftover);
        end
    endtask

endmodule

// ==== hdl/dsp_filter_top.sv ====
`timescale 1ns/1ps

// reset pin carries the clock, clk pin is the async clear
module dsp_filter_top
    import dsp_pkg::*;
    import filter_pkg::*;
(
    input  logic     reset,
    input  logic     clk,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    input  sample_t  sample_in_0,
    input  logic     sample_in_rdy_0,
    output sample_t  sample_out_0,
    output logic     sample_out_rdy_0,
    input  sample_t  sample_in_1,
    input  logic     sample_in_rdy_1,
    output sample_t  sample_out_1,
    output logic     sample_out_rdy_1
);

    coef_t             c0_b0, c0_b1, c0_b2, c0_na1, c0_na2;
    coef_t             c1_b0, c1_b1, c1_b2, c1_na1, c1_na2;
    logic [NUM_CH-1:0] dsp_req;
    logic [NUM_CH-1:0] dsp_gnt;
    sample_t           a0, a1, mac_a;
    coef_t             b0, b1, mac_b;
    opmode_t           op0, op1, mac_op;
    acc_t              mac_p;   // broadcast to both channels

    coef_regs u_coef (
        .reset(reset), .clk(clk),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .coef_ch0_b0(c0_b0), .coef_ch0_b1(c0_b1), .coef_ch0_b2(c0_b2),
        .coef_ch0_na1(c0_na1), .coef_ch0_na2(c0_na2),
        .coef_ch1_b0(c1_b0), .coef_ch1_b1(c1_b1), .coef_ch1_b2(c1_b2),
        .coef_ch1_na1(c1_na1), .coef_ch1_na2(c1_na2)
    );

    iir_channel u_ch0 (
        .reset(reset), .clk(clk),
        .coef_b0(c0_b0), .coef_b1(c0_b1), .coef_b2(c0_b2),
        .coef_na1(c0_na1), .coef_na2(c0_na2),
        .sample_in(sample_in_0), .sample_in_rdy(sample_in_rdy_0),
        .sample_out(sample_out_0), .sample_out_rdy(sample_out_rdy_0),
        .dsp_req(dsp_req[0]), .dsp_gnt(dsp_gnt[0]),
        .dsp_a(a0), .dsp_b(b0), .dsp_opmode(op0), .dsp_p(mac_p)
    );

    iir_channel u_ch1 (
        .reset(reset), .clk(clk),
        .coef_b0(c1_b0), .coef_b1(c1_b1), .coef_b2(c1_b2),
        .coef_na1(c1_na1), .coef_na2(c1_na2),
        .sample_in(sample_in_1), .sample_in_rdy(sample_in_rdy_1),
        .sample_out(sample_out_1), .sample_out_rdy(sample_out_rdy_1),
        .dsp_req(dsp_req[1]), .dsp_gnt(dsp_gnt[1]),
        .dsp_a(a1), .dsp_b(b1), .dsp_opmode(op1), .dsp_p(mac_p)
    );

    dsp_arbiter u_arb (
        .reset(reset), .clk(clk),
        .dsp_req(dsp_req), .dsp_gnt(dsp_gnt),
        .a0(a0), .a1(a1), .b0(b0), .b1(b1),
        .opmode0(op0), .opmode1(op1),
        .a(mac_a), .b(mac_b), .opmode(mac_op)
    );

    mac_unit u_mac (
        .reset(reset), .clk(clk),
        .a(mac_a), .b(mac_b), .opmode(mac_op), .p(mac_p)
    );

endmodule

// ==== hdl/coef_regs.sv ====
`timescale 1ns/1ps

module coef_regs
    import filter_pkg::*;
(
    input  logic     reset,
    input  logic     clk,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    output coef_t    coef_ch0_b0,
    output coef_t    coef_ch0_b1,
    output coef_t    coef_ch0_b2,
    output coef_t    coef_ch0_na1,
    output coef_t    coef_ch0_na2,
    output coef_t    coef_ch1_b0,
    output coef_t    coef_ch1_b1,
    output coef_t    coef_ch1_b2,
    output coef_t    coef_ch1_na1,
    output coef_t    coef_ch1_na2
);

    coef_t    coef_mem [NUM_CH][NUM_TAPS];
    logic     req;
    ch_sel_t  ch;
    tap_idx_t tap;
    logic     tap_ok;

    assign req    = wb_cyc && wb_stb && !wb_ack;    // one ack per strobe
    assign ch     = wb_adr[ADR_CH_BIT];
    assign tap    = wb_adr[ADR_CH_BIT-1:0];
    assign tap_ok = (tap < tap_idx_t'(NUM_TAPS));   // taps 5..7 unused

    // write lands together with ack
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wb_ack <= 1'b0;
            for (int c = 0; c < NUM_CH; c++) begin
                for (int t = 0; t < NUM_TAPS; t++) begin
                    coef_mem[c][t] <= '0;
                end
            end
        end else begin
            wb_ack <= req;
            if (req && wb_we && tap_ok) begin
                coef_mem[ch][tap] <= wb_dat_w;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (req) begin
            wb_dat_r <= tap_ok ? coef_mem[ch][tap] : '0;
        end
    end

    assign coef_ch0_b0  = coef_mem[0][TAP_B0];
    assign coef_ch0_b1  = coef_mem[0][TAP_B1];
    assign coef_ch0_b2  = coef_mem[0][TAP_B2];
    assign coef_ch0_na1 = coef_mem[0][TAP_NA1];
    assign coef_ch0_na2 = coef_mem[0][TAP_NA2];
    assign coef_ch1_b0  = coef_mem[1][TAP_B0];
    assign coef_ch1_b1  = coef_mem[1][TAP_B1];
    assign coef_ch1_b2  = coef_mem[1][TAP_B2];
    assign coef_ch1_na1 = coef_mem[1][TAP_NA1];
    assign coef_ch1_na2 = coef_mem[1][TAP_NA2];

    ack_in_stb: assert property (@(posedge reset) disable iff (clk) wb_ack |-> wb_stb);

endmodule

// ==== hdl/iir_channel.sv ====
`timescale 1ns/1ps

module iir_channel
    import dsp_pkg::*;
    import filter_pkg::*;
(
    input  logic    reset,
    input  logic    clk,
    input  coef_t   coef_b0,
    input  coef_t   coef_b1,
    input  coef_t   coef_b2,
    input  coef_t   coef_na1,
    input  coef_t   coef_na2,
    input  sample_t sample_in,
    input  logic    sample_in_rdy,
    output sample_t sample_out,
    output logic    sample_out_rdy,
    output logic    dsp_req,
    input  logic    dsp_gnt,
    output sample_t dsp_a,
    output coef_t   dsp_b,
    output opmode_t dsp_opmode,
    input  acc_t    dsp_p
);

    typedef enum logic [2:0] {IDLE, WAIT_GNT, CALC, DRAIN, DONE} state_t;

    state_t     state;
    state_t     state_nxt;
    tap_idx_t   tap;
    logic       tap_last;
    logic [1:0] drain_cnt;
    logic       drain_last;
    logic       accept;
    logic       capture;
    coef_t      coefs [NUM_TAPS];
    sample_t    dly   [NUM_TAPS];   // x[n], x[n-1], x[n-2], y[n-1], y[n-2]
    sample_t    y_new;

    assign tap_last   = (tap == tap_idx_t'(NUM_TAPS - 1));
    assign drain_last = (drain_cnt == 2'(MAC_LATENCY - 1));
    assign accept     = (state == IDLE) && sample_in_rdy;   // busy channel drops samples
    assign capture    = (state == DRAIN) && drain_last;     // last term is in p now
    assign y_new      = dsp_p[OUT_LSB +: $bits(sample_t)];  // plain truncation

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (sample_in_rdy) state_nxt = WAIT_GNT;
            WAIT_GNT: if (dsp_gnt)       state_nxt = CALC;
            CALC:     if (tap_last)      state_nxt = DRAIN;
            DRAIN:    if (drain_last)    state_nxt = DONE;
            DONE:     state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            tap       <= '0;
            drain_cnt <= '0;
        end else begin
            tap       <= (state == CALC && !tap_last) ? tap + 1'b1 : '0;
            drain_cnt <= (state == DRAIN) ? drain_cnt + 1'b1 : '0;
        end
    end

    // held from sample accept to the end of DONE
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            dsp_req <= 1'b0;
        end else if (accept) begin
            dsp_req <= 1'b1;
        end else if (state == DONE) begin
            dsp_req <= 1'b0;
        end
    end

    // ----------------------------------------
    // delay line
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                dly[i] <= '0;
            end
        end else if (accept) begin
            dly[0] <= sample_in;
            dly[1] <= dly[0];
            dly[2] <= dly[1];
        end else if (capture) begin
            dly[3] <= y_new;
            dly[4] <= dly[3];
        end
    end

    assign coefs[TAP_B0]  = coef_b0;
    assign coefs[TAP_B1]  = coef_b1;
    assign coefs[TAP_B2]  = coef_b2;
    assign coefs[TAP_NA1] = coef_na1;
    assign coefs[TAP_NA2] = coef_na2;

    // operand pair follows the tap counter
    assign dsp_a = dly[tap];
    assign dsp_b = coefs[tap];

    always_comb begin
        if (state == CALC) begin
            dsp_opmode = (tap == '0) ? OP_MUL : OP_MAC;
        end else begin
            dsp_opmode = OP_ZERO;
        end
    end

    // ----------------------------------------
    // output, valid during DONE
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_out_rdy <= 1'b0;
        end else begin
            sample_out_rdy <= capture;
        end
    end

    always_ff @(posedge reset) begin
        if (capture) begin
            sample_out <= y_new;
        end
    end

    req_held: assert property (@(posedge reset) disable iff (clk)
        (state != IDLE) |-> dsp_req);

    calc_len: assert property (@(posedge reset) disable iff (clk)
        (state == CALC && $past(state) != CALC)
            |-> (state == CALC) [*NUM_TAPS] ##1 (state == DRAIN));

endmodule

// ==== hdl/dsp_arbiter.sv ====
`timescale 1ns/1ps

module dsp_arbiter
    import dsp_pkg::*;
    import filter_pkg::*;
(
    input  logic              reset,
    input  logic              clk,
    input  logic [NUM_CH-1:0] dsp_req,
    output logic [NUM_CH-1:0] dsp_gnt,
    input  sample_t           a0,
    input  sample_t           a1,
    input  coef_t             b0,
    input  coef_t             b1,
    input  opmode_t           opmode0,
    input  opmode_t           opmode1,
    output sample_t           a,
    output coef_t             b,
    output opmode_t           opmode
);

    ch_sel_t           last_ch;     // last winner, loses the next tie
    logic [NUM_CH-1:0] gnt_nxt;
    logic              hold;

    // owner keeps the slice for its whole computation
    assign hold = |(dsp_gnt & dsp_req);

    always_comb begin
        gnt_nxt = '0;
        if (hold) begin
            gnt_nxt = dsp_gnt;
        end else if (last_ch == 1'b0) begin
            if (dsp_req[1])      gnt_nxt = 2'b10;
            else if (dsp_req[0]) gnt_nxt = 2'b01;
        end else begin
            if (dsp_req[0])      gnt_nxt = 2'b01;
            else if (dsp_req[1]) gnt_nxt = 2'b10;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            dsp_gnt <= '0;
            last_ch <= '0;
        end else begin
            dsp_gnt <= gnt_nxt;
            if (!hold && |gnt_nxt) begin
                last_ch <= gnt_nxt[1];
            end
        end
    end

    // ----------------------------------------
    // operand mux, idle slice clears p
    // ----------------------------------------
    always_comb begin
        a      = '0;
        b      = '0;
        opmode = OP_ZERO;
        if (dsp_gnt[0]) begin
            a      = a0;
            b      = b0;
            opmode = opmode0;
        end else if (dsp_gnt[1]) begin
            a      = a1;
            b      = b1;
            opmode = opmode1;
        end
    end

    gnt_onehot: assert property (@(posedge reset) disable iff (clk) $onehot0(dsp_gnt));

    // a new grant needs a request in the cycle before
    gnt_to_req: assert property (@(posedge reset) disable iff (clk)
        (dsp_gnt & ~$past(dsp_gnt) & ~$past(dsp_req)) == '0);

endmodule

// ==== hdl/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit
    import dsp_pkg::*;
    import filter_pkg::*;
(
    input  logic    reset,
    input  logic    clk,
    input  sample_t a,
    input  coef_t   b,
    input  opmode_t opmode,
    output acc_t    p
);

    sample_t a_r;
    coef_t   b_r;
    opmode_t op_r;
    prod_t   prod;

    // ----------------------------------------
    // stage 1, operand registers
    // ----------------------------------------
    always_ff @(posedge reset) begin
        a_r <= a;
        b_r <= b;
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_r <= OP_ZERO;
        end else begin
            op_r <= opmode;
        end
    end

    assign prod = a_r * b_r;    // signed 18x18

    // ----------------------------------------
    // stage 2, accumulator
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p <= '0;
        end else begin
            case (op_r)
                OP_MUL:  p <= acc_t'(prod);         // first term of a sum
                OP_MAC:  p <= p + acc_t'(prod);
                default: p <= '0;
            endcase
        end
    end

endmodule

// ==== hdl/filter_pkg.sv ====
package filter_pkg;

    // ----------------------------------------
    // sample and coefficient formats
    // ----------------------------------------
    typedef logic signed [17:0] sample_t;   // Q2.16
    typedef logic signed [17:0] coef_t;     // Q2.16

    localparam int NUM_CH   = 2;
    localparam int NUM_TAPS = 5;

    typedef logic [0:0] ch_sel_t;
    typedef logic [2:0] tap_idx_t;

    // tap order, feedback terms stored negated
    localparam int TAP_B0  = 0;
    localparam int TAP_B1  = 1;
    localparam int TAP_B2  = 2;
    localparam int TAP_NA1 = 3;
    localparam int TAP_NA2 = 4;

    // ----------------------------------------
    // coefficient register map
    // ----------------------------------------
    typedef logic [3:0]  wb_addr_t;   // {ch, tap[2:0]}
    typedef logic [17:0] wb_data_t;

    localparam int ADR_CH_BIT = 3;    // taps sit below this bit

endpackage

// ==== hdl/dsp_pkg.sv ====
package dsp_pkg;

    // ----------------------------------------
    // shared MAC slice
    // ----------------------------------------

    // stage 2 accumulator control
    typedef enum logic [1:0] {
        OP_ZERO = 2'b00,    // clear p
        OP_MUL  = 2'b01,    // p = a*b
        OP_MAC  = 2'b10     // p = p + a*b
    } opmode_t;

    typedef logic signed [47:0] acc_t;     // DSP48 style accumulator
    typedef logic signed [35:0] prod_t;    // full 18x18 product

    // operand in to accumulator updated
    localparam int MAC_LATENCY = 2;

    // lsb of the output slice taken from p, Q2.16 result
    localparam int OUT_LSB = 16;

endpackage
